// File: Bender.yml
package:
  name: gpio_harness

sources:
  # packages first, the modules import them
  - files:
      - logic/harness_pkg.sv
      - logic/design_pkg.sv
      - logic/reset_router.sv
      - logic/blinky_counter.sv
      - logic/pwm_generator.sv
      - logic/lfsr_pattern.sv
      - logic/integrated_designs.sv

  # testbench only in simulation
  - target: test
    files:
      - tb/tb_integrated_designs.sv

// File: gpio_harness.f
logic/harness_pkg.sv
logic/design_pkg.sv
logic/reset_router.sv
logic/blinky_counter.sv
logic/pwm_generator.sv
logic/lfsr_pattern.sv
logic/integrated_designs.sv
tb/tb_integrated_designs.sv

// File: logic/blinky_counter.sv
module blinky_counter
    import harness_pkg::*;
    import design_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    // not read here, present so every slot has the same port shape
    input  gpio_t      gpio_in,
    output gpio_port_t pads
);

    // free running count
    blink_cnt_t count;

    // wraps naturally at 2^16
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // count goes straight out of its register
    assign pads.out = gpio_t'(count) << BLINK_OUT_LSB;

    // drive only the counter pads
    // everything else stays an input, also during reset
    assign pads.oeb = ~(gpio_t'({$bits(blink_cnt_t){1'b1}}) << BLINK_OUT_LSB);

endmodule

// File: logic/design_pkg.sv
package design_pkg;

    // slot 1 counter value
    typedef logic [15:0] blink_cnt_t;

    // slot 2 duty cycle and pwm period counter
    typedef logic [7:0] pwm_duty_t;

    // slot 3 lfsr state
    typedef logic [15:0] lfsr_t;

    // lfsr reset state, must be nonzero
    localparam lfsr_t LFSR_SEED = 16'h0001;

    // galois mask for x^16 + x^14 + x^13 + x^11 + 1, right shifting
    localparam lfsr_t LFSR_TAPS = 16'hB400;

    // pad positions
    // counter drives the bottom pads
    localparam int BLINK_OUT_LSB = 0;
    // duty byte is read starting here
    localparam int PWM_DUTY_LSB = 0;
    // single pwm output pad
    localparam int PWM_OUT_PIN = 16;
    // lfsr steps while this pad is high
    localparam int LFSR_EN_PIN = 0;
    // lfsr state shows on the upper half
    localparam int LFSR_OUT_LSB = 16;

endpackage

// File: logic/harness_pkg.sv
package harness_pkg;

    // number of user pads shared by every design
    localparam int GPIO_WIDTH = 34;

    // one bit per pad
    typedef logic [GPIO_WIDTH-1:0] gpio_t;

    // 0 selects nothing, 1 to NUM_DESIGNS pick a slot
    typedef logic [3:0] design_sel_t;

    // populated slots, the remaining codes fall into the idle case
    localparam int NUM_DESIGNS = 3;

    // per-slot flags, numbered from 1 like the select code
    typedef logic [NUM_DESIGNS:1] slot_mask_t;

    // cycles a slot stays in reset after it gets selected
    localparam int RESET_HOLD = 2;

    // hold counter only needs to reach RESET_HOLD
    typedef logic [$clog2(RESET_HOLD+1)-1:0] hold_cnt_t;

    // pad bundle each design hands back to the top
    // oeb is active low, so a 0 drives the pad
    typedef struct packed {
        gpio_t out;
        gpio_t oeb;
    } gpio_port_t;

endpackage

// File: logic/integrated_designs.sv
module integrated_designs import harness_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    // 0 is no design, 1 to NUM_DESIGNS pick a slot
    input  design_sel_t design_select,
    input  gpio_t       gpio_in,
    output gpio_t       gpio_out,
    output gpio_t       gpio_oeb
);

    // active high reset per slot
    slot_mask_t design_reset;

    // pad bundles indexed like the select code
    gpio_port_t slot_pads [1:NUM_DESIGNS];

    // keeps unselected slots in reset and holds a new one briefly
    reset_router i_reset_router (
        .clk           (clk),
        .reset         (reset),
        .design_select (design_select),
        .design_reset  (design_reset)
    );

    // every slot sees all pads
    // the unselected ones sit in reset so the inputs do nothing there

    // slot 1
    blinky_counter i_blinky_counter (
        .clk     (clk),
        .reset   (design_reset[1]),
        .gpio_in (gpio_in),
        .pads    (slot_pads[1])
    );

    // slot 2
    pwm_generator i_pwm_generator (
        .clk     (clk),
        .reset   (design_reset[2]),
        .gpio_in (gpio_in),
        .pads    (slot_pads[2])
    );

    // slot 3
    lfsr_pattern i_lfsr_pattern (
        .clk     (clk),
        .reset   (design_reset[3]),
        .gpio_in (gpio_in),
        .pads    (slot_pads[3])
    );

    // output mux, purely combinational on the select
    // codes without a design leave all pads as inputs with zero outputs
    always_comb begin
        gpio_out = '0;
        gpio_oeb = '1;
        if ((design_select != '0) &&
            (design_select <= design_sel_t'(NUM_DESIGNS))) begin
            gpio_out = slot_pads[design_select].out;
            gpio_oeb = slot_pads[design_select].oeb;
        end
    end

endmodule

// File: logic/lfsr_pattern.sv
module lfsr_pattern
    import harness_pkg::*;
    import design_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  gpio_t      gpio_in,
    output gpio_port_t pads
);

    // current state
    lfsr_t state;
    // state after one galois step
    lfsr_t state_step;

    // shift right and fold the taps in when the lsb falls out high
    always_comb begin
        if (state[0]) begin
            state_step = (state >> 1) ^ LFSR_TAPS;
        end else begin
            state_step = state >> 1;
        end
    end

    // steps only while the enable pad is high
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= LFSR_SEED;
        end else if (gpio_in[LFSR_EN_PIN]) begin
            state <= state_step;
        end
    end

    // state shows on the upper pads
    assign pads.out = gpio_t'(state) << LFSR_OUT_LSB;

    // enable pad and the rest remain inputs
    // mask is fixed so it holds through reset as well
    assign pads.oeb = ~(gpio_t'({$bits(lfsr_t){1'b1}}) << LFSR_OUT_LSB);

endmodule

// File: logic/pwm_generator.sv
module pwm_generator
    import harness_pkg::*;
    import design_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  gpio_t      gpio_in,
    output gpio_port_t pads
);

    // duty byte sampled from the pads
    pwm_duty_t duty_q;
    // period counter, 256 cycles per period
    pwm_duty_t pwm_cnt;
    // registered pwm level
    logic      pwm_q;

    // duty is plain data and follows the pads every cycle
    always_ff @(posedge clk) begin
        duty_q <= gpio_in[PWM_DUTY_LSB +: $bits(pwm_duty_t)];
    end

    // high while the counter is below the duty
    // so a duty of N gives N high cycles per period
    always_ff @(posedge clk) begin
        if (reset) begin
            pwm_cnt <= '0;
            pwm_q   <= 1'b0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
            pwm_q   <= (pwm_cnt < duty_q);
        end
    end

    // single output pad
    assign pads.out = gpio_t'(pwm_q) << PWM_OUT_PIN;

    // only the pwm pad is driven, the duty pads stay inputs
    assign pads.oeb = ~(gpio_t'(1'b1) << PWM_OUT_PIN);

endmodule

// File: logic/reset_router.sv
module reset_router import harness_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  design_sel_t design_select,
    output slot_mask_t  design_reset
);

    // select as seen on the previous edge
    design_sel_t sel_q;
    // cycles since the last select change, saturates at RESET_HOLD
    hold_cnt_t   hold_cnt;
    hold_cnt_t   hold_next;
    slot_mask_t  reset_next;

    // any change of the select restarts the hold
    always_comb begin
        if (design_select != sel_q) begin
            hold_next = '0;
        end else if (hold_cnt == hold_cnt_t'(RESET_HOLD)) begin
            hold_next = hold_cnt;
        end else begin
            hold_next = hold_cnt + 1'b1;
        end
    end

    // per-slot reset from the values the registers take on this edge
    // so the slot leaves reset exactly RESET_HOLD+1 edges after the change
    always_comb begin
        for (int slot = 1; slot <= NUM_DESIGNS; slot++) begin
            reset_next[slot] = (design_select != design_sel_t'(slot)) ||
                               (hold_next < hold_cnt_t'(RESET_HOLD));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sel_q        <= '0;
            hold_cnt     <= '0;
            // everything parked until a select settles
            design_reset <= '1;
        end else begin
            sel_q        <= design_select;
            hold_cnt     <= hold_next;
            design_reset <= reset_next;
        end
    end

endmodule

// File: tb/tb_integrated_designs.sv
module tb_integrated_designs
    import harness_pkg::*;
    import design_pkg::*;
();

    logic        clk = 1'b0;
    logic        reset;
    design_sel_t design_select;
    gpio_t       gpio_in;
    gpio_t       gpio_out;
    gpio_t       gpio_oeb;

    // xorshift state and the code visiting order
    logic [31:0] rng;
    design_sel_t order [16];
    design_sel_t cur_code;

    // reference model state for the selected slot
    blink_cnt_t  blink_m;
    pwm_duty_t   pwm_cnt_m;
    pwm_duty_t   duty;
    logic        pwm_q_m;
    lfsr_t       lfsr_m;
    // enable pad value the dut sees on the next edge
    logic        en_prev;
    // pwm highs over an aligned 256 sample window
    int          high_cnt;
    int          win_len;

    integrated_designs i_integrated_designs (
        .clk           (clk),
        .reset         (reset),
        .design_select (design_select),
        .gpio_in       (gpio_in),
        .gpio_out      (gpio_out),
        .gpio_oeb      (gpio_oeb)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // right shift, taps 16, 14, 13 and 11 folded in when the dropped bit is set
    // tap n of the polynomial lands on bit n-1
    function automatic lfsr_t galois_step(input lfsr_t s);
        lfsr_t fb;
        fb = '0;
        if (s[0]) begin
            fb[15] = 1'b1;
            fb[13] = 1'b1;
            fb[12] = 1'b1;
            fb[10] = 1'b1;
        end
        return {1'b0, s[15:1]} ^ fb;
    endfunction

    // pads each slot drives, zero means driven
    function automatic gpio_t oeb_mask(input design_sel_t code);
        case (code)
            4'd1:    return ~gpio_t'(16'hFFFF);
            4'd2:    return ~(gpio_t'(1'b1) << PWM_OUT_PIN);
            4'd3:    return ~(gpio_t'(16'hFFFF) << 16);
            default: return '1;
        endcase
    endfunction

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at time %0t: %s", $time, msg);
        $display(">>> FAIL");
        $fatal(1, "stopping on first mismatch");
    endtask

    task automatic report_stuck(input string msg);
        $display("simulation stuck at time %0t: %s", $time, msg);
        $display(">>> FAIL");
        $fatal(1, "stopping on timeout");
    endtask

    // select 0 during reset, the pads must settle to the idle state
    task automatic wait_for_idle();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!(gpio_oeb === '1 && gpio_out === '0) && waited < 20) begin
            waited++;
            @(negedge clk);
        end
        if (!(gpio_oeb === '1 && gpio_out === '0)) begin
            report_stuck("pads never went idle after reset");
        end
    endtask

    // fisher yates over all sixteen codes
    task automatic shuffle_codes();
        int          j;
        design_sel_t tmp;
        for (int i = 15; i > 0; i--) begin
            rng = xorshift32(rng);
            j = int'(rng % (i + 1));
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        // every step of the sequence has to be a real change
        if (order[0] == cur_code) begin
            tmp = order[0];
            order[0] = order[1];
            order[1] = tmp;
        end
    endtask

    // switch to code and check every cycle of the dwell against the model
    task automatic run_dwell(input design_sel_t code, input int cycles);
        gpio_t g;
        gpio_t exp_out;
        rng = xorshift32(rng);
        duty = rng[7:0];
        for (int d = 0; d < cycles; d++) begin
            @(posedge clk);
            rng = xorshift32(rng);
            g[31:0] = rng;
            rng = xorshift32(rng);
            g[33:32] = rng[1:0];
            // duty byte held for the whole pwm dwell
            if (code == 4'd2) begin
                g[PWM_DUTY_LSB +: 8] = duty;
            end
            if (d == 0) begin
                design_select <= code;
            end
            gpio_in <= g;
            @(negedge clk);
            // slot sits at its reset value through the hold edges
            if (d <= RESET_HOLD + 1) begin
                blink_m   = '0;
                pwm_cnt_m = '0;
                pwm_q_m   = 1'b0;
                lfsr_m    = LFSR_SEED;
                high_cnt  = 0;
                win_len   = 0;
            end else begin
                blink_m   = blink_m + 1'b1;
                pwm_q_m   = (pwm_cnt_m < duty);
                pwm_cnt_m = pwm_cnt_m + 1'b1;
                if (en_prev) begin
                    lfsr_m = galois_step(lfsr_m);
                end
            end
            en_prev = g[LFSR_EN_PIN];
            case (code)
                4'd1:    exp_out = gpio_t'(blink_m);
                4'd2:    exp_out = gpio_t'(pwm_q_m) << PWM_OUT_PIN;
                4'd3:    exp_out = gpio_t'(lfsr_m) << 16;
                default: exp_out = '0;
            endcase
            assert (gpio_oeb === oeb_mask(code)) else
                report_mismatch($sformatf("code %0d cycle %0d gpio_oeb %h expected %h",
                                          code, d, gpio_oeb, oeb_mask(code)));
            assert (gpio_out === exp_out) else
                report_mismatch($sformatf("code %0d cycle %0d gpio_out %h expected %h",
                                          code, d, gpio_out, exp_out));
            // one full pwm period carries exactly duty highs
            if (code == 4'd2 && d > RESET_HOLD + 1) begin
                high_cnt += int'(gpio_out[PWM_OUT_PIN]);
                win_len++;
                if (win_len == 256) begin
                    assert (high_cnt == int'(duty)) else
                        report_mismatch($sformatf("pwm period has %0d highs, duty %0d",
                                                  high_cnt, duty));
                    high_cnt = 0;
                    win_len  = 0;
                end
            end
        end
        cur_code = code;
    endtask

    initial begin
        reset         = 1'b1;
        design_select = '0;
        gpio_in       = '0;
        rng           = 32'd31;
        cur_code      = '0;
        en_prev       = 1'b0;
        for (int i = 0; i < 16; i++) begin
            order[i] = design_sel_t'(i);
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        wait_for_idle();
        // three passes over all codes, random dwell of 300 to 600 cycles
        for (int round = 0; round < 3; round++) begin
            shuffle_codes();
            for (int i = 0; i < 16; i++) begin
                rng = xorshift32(rng);
                run_dwell(order[i], 300 + int'(rng % 301));
            end
        end
        $display(">>> PASS");
        $finish;
    end

endmodule
